// ==== src.f ====
design/npc_pkg.sv
design/npc_ifu.sv
design/npc_idu.sv
design/npc_regfile.sv
design/npc_exu.sv
design/npc_top.sv
verif/npc_properties.sv
verif/npc_tb.sv

// ==== Makefile ====
# Verilator build and run of the rv64i core testbench

VERILATOR ?= verilator
TOP       ?= npc_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST RESULT: PASS'

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/npc_tb.sv ====
// rv64i core testbench
`timescale 1ns/1ps

module npc_tb;

	// one expected retirement
	typedef struct packed {
		logic [63:0] pc;
		logic        en;
		logic [4:0]  rd;
		logic [63:0] data;
		logic [2:0]  grp;
	} expect_t;

	localparam int prog_len = 35;
	localparam logic [31:0] nop_word = 32'h0000_0013;

	logic                    clk;
	logic                    rst;
	logic [63:0]             pc;
	logic [31:0]             inst;
	npc_pkg::retire_t        retire;
	logic                    halted;

	logic [31:0] prog [0:prog_len-1];
	expect_t     exp_q [$];
	int          errors;
	int          samples;
	int          cycles;

	npc_top uut (
		.clk    (clk),
		.rst    (rst),
		.pc     (pc),
		.inst   (inst),
		.retire (retire),
		.halted (halted)
	);

	bind npc_top npc_properties props (
		.clk    (clk),
		.rst    (rst),
		.pc     (pc),
		.halted (halted),
		.dec    (dec),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.retire (retire)
	);

	// instruction encoders, field order per the isa formats
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	// offset bit 0 is implied zero
	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// word at addr, nop outside the program
	function automatic logic [31:0] fetch_word(input logic [63:0] addr);
		logic [63:0] off;
		off = addr - npc_pkg::reset_pc;
		if ($isunknown(addr) || addr < npc_pkg::reset_pc) begin
			return nop_word;
		end
		if (off < 64'(4 * prog_len) && off[1:0] == 2'b00) begin
			return prog[off[7:2]];
		end
		return nop_word;
	endfunction

	function automatic string test_title(input int grp);
		case (grp)
			1:       return "reset and pc sequence";
			2:       return "alu register and immediate ops";
			3:       return "x0 write and read";
			4:       return "lui auipc branches and jumps";
			default: return "ebreak halt";
		endcase
	endfunction

	task automatic expect_retire(input logic [63:0] rpc, input logic en, input logic [4:0] rd,
		input logic [63:0] data, input logic [2:0] grp);
		expect_t e;
		e.pc   = rpc;
		e.en   = en;
		e.rd   = rd;
		e.data = data;
		e.grp  = grp;
		exp_q.push_back(e);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] got);
		$display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
		errors++;
	endtask

	task automatic print_test(input int grp, input int errs);
		if (errs == 0) begin
			$display("test %0d %s: ok", grp, test_title(grp));
		end else begin
			$display("test %0d %s: %0d errors", grp, test_title(grp), errs);
		end
	endtask

	task automatic load_program();
		// skipped slots hold addi x18 with their own index
		for (int i = 0; i < prog_len; i++) begin
			prog[i] = i_type(12'(i), 5'd0, 3'b000, 5'd18, npc_pkg::op_imm);
		end
		prog[0]  = i_type(12'd5, 5'd0, 3'b000, 5'd1, npc_pkg::op_imm);
		prog[1]  = i_type(12'hffd, 5'd0, 3'b000, 5'd2, npc_pkg::op_imm);
		prog[2]  = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, npc_pkg::op_reg);
		prog[3]  = r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd4, npc_pkg::op_reg);
		prog[4]  = r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd5, npc_pkg::op_reg);
		prog[5]  = r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd6, npc_pkg::op_reg);
		// srai, srli, slli with rv64 shift amounts
		prog[6]  = i_type(12'h401, 5'd4, 3'b101, 5'd7, npc_pkg::op_imm);
		prog[7]  = i_type(12'd60, 5'd4, 3'b101, 5'd8, npc_pkg::op_imm);
		prog[8]  = i_type(12'd62, 5'd1, 3'b001, 5'd9, npc_pkg::op_imm);
		prog[9]  = i_type(12'hfff, 5'd1, 3'b100, 5'd10, npc_pkg::op_imm);
		prog[10] = r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd11, npc_pkg::op_reg);
		prog[11] = r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd12, npc_pkg::op_reg);
		prog[12] = u_type(20'h7ffff, 5'd13, npc_pkg::op_lui);
		prog[13] = r_type(7'h00, 5'd13, 5'd13, 3'b000, 5'd14, npc_pkg::op_reg_32);
		prog[14] = i_type(12'd31, 5'd1, 3'b001, 5'd15, npc_pkg::op_imm_32);
		// write to x0 then read it back
		prog[15] = i_type(12'd7, 5'd1, 3'b000, 5'd0, npc_pkg::op_imm);
		prog[16] = r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd16, npc_pkg::op_reg);
		prog[17] = u_type(20'h00001, 5'd17, npc_pkg::op_auipc);
		prog[18] = b_type(13'd8, 5'd12, 5'd1, 3'b000);
		prog[20] = b_type(13'd8, 5'd12, 5'd1, 3'b001);
		prog[21] = b_type(13'd8, 5'd1, 5'd2, 3'b100);
		prog[23] = b_type(13'd8, 5'd1, 5'd2, 3'b111);
		prog[25] = j_type(21'd12, 5'd19);
		prog[28] = u_type(20'h00000, 5'd20, npc_pkg::op_auipc);
		// odd target, bit 0 must drop
		prog[29] = i_type(12'd17, 5'd20, 3'b000, 5'd21, npc_pkg::op_jalr);
		prog[32] = u_type(20'hfffff, 5'd22, npc_pkg::op_lui);
		prog[33] = b_type(13'd8, 5'd2, 5'd1, 3'b100);
		prog[34] = 32'h0010_0073;
	endtask

	task automatic build_expects();
		expect_retire(64'h8000_0000, 1'b1, 5'd1, 64'h0000_0000_0000_0005, 3'd1);
		expect_retire(64'h8000_0004, 1'b1, 5'd2, 64'hffff_ffff_ffff_fffd, 3'd1);
		expect_retire(64'h8000_0008, 1'b1, 5'd3, 64'h0000_0000_0000_0002, 3'd2);
		expect_retire(64'h8000_000c, 1'b1, 5'd4, 64'hffff_ffff_ffff_fff8, 3'd2);
		expect_retire(64'h8000_0010, 1'b1, 5'd5, 64'h0000_0000_0000_0001, 3'd2);
		expect_retire(64'h8000_0014, 1'b1, 5'd6, 64'h0000_0000_0000_0000, 3'd2);
		expect_retire(64'h8000_0018, 1'b1, 5'd7, 64'hffff_ffff_ffff_fffc, 3'd2);
		expect_retire(64'h8000_001c, 1'b1, 5'd8, 64'h0000_0000_0000_000f, 3'd2);
		expect_retire(64'h8000_0020, 1'b1, 5'd9, 64'h4000_0000_0000_0000, 3'd2);
		expect_retire(64'h8000_0024, 1'b1, 5'd10, 64'hffff_ffff_ffff_fffa, 3'd2);
		expect_retire(64'h8000_0028, 1'b1, 5'd11, 64'hffff_ffff_ffff_fffd, 3'd2);
		expect_retire(64'h8000_002c, 1'b1, 5'd12, 64'h0000_0000_0000_0005, 3'd2);
		expect_retire(64'h8000_0030, 1'b1, 5'd13, 64'h0000_0000_7fff_f000, 3'd2);
		expect_retire(64'h8000_0034, 1'b1, 5'd14, 64'hffff_ffff_ffff_e000, 3'd2);
		expect_retire(64'h8000_0038, 1'b1, 5'd15, 64'hffff_ffff_8000_0000, 3'd2);
		expect_retire(64'h8000_003c, 1'b1, 5'd0, 64'h0000_0000_0000_000c, 3'd3);
		expect_retire(64'h8000_0040, 1'b1, 5'd16, 64'h0000_0000_0000_0000, 3'd3);
		expect_retire(64'h8000_0044, 1'b1, 5'd17, 64'h0000_0000_8000_1044, 3'd4);
		// branches write nothing, the next pc shows the outcome
		expect_retire(64'h8000_0048, 1'b0, 5'd0, 64'h0, 3'd4);
		expect_retire(64'h8000_0050, 1'b0, 5'd0, 64'h0, 3'd4);
		expect_retire(64'h8000_0054, 1'b0, 5'd0, 64'h0, 3'd4);
		expect_retire(64'h8000_005c, 1'b0, 5'd0, 64'h0, 3'd4);
		expect_retire(64'h8000_0064, 1'b1, 5'd19, 64'h0000_0000_8000_0068, 3'd4);
		expect_retire(64'h8000_0070, 1'b1, 5'd20, 64'h0000_0000_8000_0070, 3'd4);
		expect_retire(64'h8000_0074, 1'b1, 5'd21, 64'h0000_0000_8000_0078, 3'd4);
		expect_retire(64'h8000_0080, 1'b1, 5'd22, 64'hffff_ffff_ffff_f000, 3'd4);
		expect_retire(64'h8000_0084, 1'b0, 5'd0, 64'h0, 3'd4);
		expect_retire(64'h8000_0088, 1'b0, 5'd0, 64'h0, 3'd5);
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// instruction port model, word follows pc
	initial begin
		inst = nop_word;
		forever begin
			@(posedge clk);
			#2;
			inst = fetch_word(pc);
		end
	end

	// run limit scales with the table
	initial begin
		cycles = 0;
		while (cycles < 4 * exp_q.size() + 40) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, core stopped retiring as expected", cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		expect_t e;
		int      err_mark;
		rst     = 1'b1;
		errors  = 0;
		samples = 0;
		load_program();
		build_expects();
		err_mark = 0;

		// no retirement and no halt while in reset
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			#2;
			if (retire.wb_en !== 1'b0) begin
				report_mismatch("retire.wb_en", 64'd0, 64'(retire.wb_en));
			end
			if (halted !== 1'b0) begin
				report_mismatch("halted", 64'd0, 64'(halted));
			end
		end
		rst = 1'b0;

		// one retirement per cycle, sampled mid-cycle
		for (int i = 0; i < exp_q.size(); i++) begin
			e = exp_q[i];
			@(negedge clk);
			samples++;
			if (retire.pc !== e.pc) begin
				report_mismatch("retire.pc", e.pc, retire.pc);
			end
			if (retire.inst !== fetch_word(e.pc)) begin
				report_mismatch("retire.inst", 64'(fetch_word(e.pc)), 64'(retire.inst));
			end
			if (retire.wb_en !== e.en) begin
				report_mismatch("retire.wb_en", 64'(e.en), 64'(retire.wb_en));
			end
			if (e.en && retire.wb_rd !== e.rd) begin
				report_mismatch("retire.wb_rd", 64'(e.rd), 64'(retire.wb_rd));
			end
			if (e.en && retire.wb_data !== e.data) begin
				report_mismatch("retire.wb_data", e.data, retire.wb_data);
			end
			if (i + 1 < exp_q.size() && exp_q[i + 1].grp != e.grp) begin
				print_test(int'(e.grp), errors - err_mark);
				err_mark = errors;
			end
		end

		// halt flag one edge after ebreak, then pc frozen
		@(negedge clk);
		samples++;
		if (halted !== 1'b1) begin
			$display("FAIL t=%0t halted did not rise within one cycle of EBREAK", $time);
			errors++;
		end
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			samples++;
			if (pc !== 64'h8000_0088) begin
				report_mismatch("pc", 64'h8000_0088, pc);
			end
			if (retire.wb_en !== 1'b0) begin
				report_mismatch("retire.wb_en", 64'd0, 64'(retire.wb_en));
			end
			if (halted !== 1'b1) begin
				report_mismatch("halted", 64'd1, 64'(halted));
			end
		end
		print_test(5, errors - err_mark);

		$display("%0d samples checked, %0d errors", samples, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== verif/npc_properties.sv ====
// rv64i core invariants
`timescale 1ns/1ps

module npc_properties (
	input logic                      clk,
	input logic                      rst,
	input logic [npc_pkg::xlen-1:0]  pc,
	input logic                      halted,
	input npc_pkg::dec_t             dec,
	input logic [npc_pkg::xlen-1:0]  rdata1,
	input logic [npc_pkg::xlen-1:0]  rdata2,
	input npc_pkg::retire_t          retire
);

	// no compressed ops, fetch stays on word boundaries
	property pc_word_aligned;
		@(posedge clk) disable iff (rst) pc[1:0] == 2'b00;
	endproperty

	// a reported write to x1..x31 reads back next cycle, x0 writes stay out
	property write_reads_back;
		@(posedge clk) disable iff (rst)
			(retire.wb_en && retire.wb_rd != 5'd0) |=>
				(dec.rs1 != $past(retire.wb_rd) || rdata1 == $past(retire.wb_data)) &&
				(dec.rs2 != $past(retire.wb_rd) || rdata2 == $past(retire.wb_data));
	endproperty

	// halt is sticky and freezes the fetch address
	property halt_holds_pc;
		@(posedge clk) disable iff (rst) halted |=> (halted && $stable(pc));
	endproperty

	assert property (pc_word_aligned) else $error("pc is not word aligned");
	assert property (write_reads_back) else $error("retired write did not reach the register file");
	assert property (halt_holds_pc) else $error("pc moved or halt dropped while halted");

endmodule

// ==== design/npc_top.sv ====
// rv64i single-cycle core top level
`timescale 1ns/1ps

module npc_top (
	input  logic                      clk,
	input  logic                      rst,
	output logic [npc_pkg::xlen-1:0]  pc,
	input  logic [npc_pkg::ilen-1:0]  inst,
	output npc_pkg::retire_t          retire,
	output logic                      halted
);

	npc_pkg::dec_t            dec;
	logic [npc_pkg::xlen-1:0] rdata1;
	logic [npc_pkg::xlen-1:0] rdata2;
	logic                     rf_we;
	logic [4:0]               rf_waddr;
	logic [npc_pkg::xlen-1:0] rf_wdata;
	logic [npc_pkg::xlen-1:0] dnpc;
	logic                     take_halt;
	logic                     exu_block;

	// no retirement while halted or held in reset
	assign exu_block = halted | rst;

	// fetch
	npc_ifu ifu (
		.clk       (clk),
		.rst       (rst),
		.dnpc      (dnpc),
		.take_halt (take_halt),
		.pc        (pc),
		.halted    (halted)
	);

	// decode straight off the instruction port
	npc_idu idu (
		.inst (inst),
		.dec  (dec)
	);

	npc_regfile regfile (
		.clk    (clk),
		.rst    (rst),
		.rs1    (dec.rs1),
		.rs2    (dec.rs2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.we     (rf_we),
		.waddr  (rf_waddr),
		.wdata  (rf_wdata)
	);

	// execute and write-back
	npc_exu exu (
		.pc        (pc),
		.inst      (inst),
		.dec       (dec),
		.rdata1    (rdata1),
		.rdata2    (rdata2),
		.halted    (exu_block),
		.we        (rf_we),
		.waddr     (rf_waddr),
		.wdata     (rf_wdata),
		.dnpc      (dnpc),
		.take_halt (take_halt),
		.retire    (retire)
	);

endmodule

// ==== design/npc_exu.sv ====
// rv64i execute unit
`timescale 1ns/1ps

module npc_exu (
	input  logic [npc_pkg::xlen-1:0]  pc,
	input  logic [npc_pkg::ilen-1:0]  inst,
	input  npc_pkg::dec_t             dec,
	input  logic [npc_pkg::xlen-1:0]  rdata1,
	input  logic [npc_pkg::xlen-1:0]  rdata2,
	input  logic                      halted,
	output logic                      we,
	output logic [4:0]                waddr,
	output logic [npc_pkg::xlen-1:0]  wdata,
	output logic [npc_pkg::xlen-1:0]  dnpc,
	output logic                      take_halt,
	output npc_pkg::retire_t          retire
);

	logic [npc_pkg::xlen-1:0] src_a;
	logic [npc_pkg::xlen-1:0] src_b;
	logic [npc_pkg::xlen-1:0] sh_src;
	logic [5:0]               shamt;
	logic [npc_pkg::xlen-1:0] alu_raw;
	logic [npc_pkg::xlen-1:0] alu_res;
	logic [npc_pkg::xlen-1:0] pc_seq;
	logic [npc_pkg::xlen-1:0] br_target;
	logic [npc_pkg::xlen-1:0] jalr_target;
	logic                     cmp_eq;
	logic                     cmp_lt;
	logic                     cmp_ltu;
	logic                     taken;
	logic                     stop;

	// operand muxes
	assign src_a = dec.src_a_pc ? pc : rdata1;
	assign src_b = dec.src_b_imm ? dec.imm : rdata2;

	// word shifts see only the low 32 bits of a, 5-bit shamt
	assign shamt = dec.word_op ? {1'b0, src_b[4:0]} : src_b[5:0];
	always_comb begin
		sh_src = src_a;
		if (dec.word_op) begin
			if (dec.alu_op == npc_pkg::alu_sra) begin
				sh_src = {{32{src_a[31]}}, src_a[31:0]};
			end else begin
				sh_src = {32'b0, src_a[31:0]};
			end
		end
	end

	always_comb begin
		case (dec.alu_op)
			npc_pkg::alu_add:  alu_raw = src_a + src_b;
			npc_pkg::alu_sub:  alu_raw = src_a - src_b;
			npc_pkg::alu_sll:  alu_raw = sh_src << shamt;
			npc_pkg::alu_slt:  alu_raw = {63'b0, $signed(src_a) < $signed(src_b)};
			npc_pkg::alu_sltu: alu_raw = {63'b0, src_a < src_b};
			npc_pkg::alu_xor:  alu_raw = src_a ^ src_b;
			npc_pkg::alu_srl:  alu_raw = sh_src >> shamt;
			npc_pkg::alu_sra:  alu_raw = $signed(sh_src) >>> shamt;
			npc_pkg::alu_or:   alu_raw = src_a | src_b;
			default:           alu_raw = src_a & src_b;
		endcase
	end

	// w-suffix results sign-extend from bit 31
	assign alu_res = dec.word_op ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

	// branch compare always on the two register values
	assign cmp_eq  = (rdata1 == rdata2);
	assign cmp_lt  = ($signed(rdata1) < $signed(rdata2));
	assign cmp_ltu = (rdata1 < rdata2);

	always_comb begin
		case (dec.br_op)
			npc_pkg::br_beq:  taken = cmp_eq;
			npc_pkg::br_bne:  taken = !cmp_eq;
			npc_pkg::br_blt:  taken = cmp_lt;
			npc_pkg::br_bge:  taken = !cmp_lt;
			npc_pkg::br_bltu: taken = cmp_ltu;
			npc_pkg::br_bgeu: taken = !cmp_ltu;
			npc_pkg::br_jal:  taken = 1'b1;
			default:          taken = 1'b0;
		endcase
	end

	// next pc candidates
	assign pc_seq      = pc + 64'd4;
	assign br_target   = pc + dec.imm;
	assign jalr_target = {alu_res[npc_pkg::xlen-1:1], 1'b0};

	always_comb begin
		if (dec.br_op == npc_pkg::br_jalr) begin
			dnpc = jalr_target;
		end else if (taken) begin
			dnpc = br_target;
		end else begin
			dnpc = pc_seq;
		end
	end

	// ebreak and illegal words both stop the core
	assign stop      = dec.ebreak | dec.illegal;
	assign take_halt = !halted & stop;

	// write-back, link ops take pc + 4
	assign we    = dec.rd_we & !halted & !stop;
	assign waddr = dec.rd;
	assign wdata = dec.rd_is_link ? pc_seq : alu_res;

	always_comb begin
		retire.pc      = pc;
		retire.inst    = inst;
		retire.wb_en   = we;
		retire.wb_rd   = waddr;
		retire.wb_data = wdata;
	end

endmodule

// ==== design/npc_regfile.sv ====
// rv64i integer register file
`timescale 1ns/1ps

module npc_regfile (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [4:0]                rs1,
	input  logic [4:0]                rs2,
	output logic [npc_pkg::xlen-1:0]  rdata1,
	output logic [npc_pkg::xlen-1:0]  rdata2,
	input  logic                      we,
	input  logic [4:0]                waddr,
	input  logic [npc_pkg::xlen-1:0]  wdata
);

	// x1..x31, x0 has no storage
	logic [npc_pkg::xlen-1:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != 5'd0)) begin
			// writes to x0 fall away here
			regs[waddr] <= wdata;
		end
	end

	// combinational read ports
	always_comb begin
		rdata1 = '0;
		rdata2 = '0;
		if (rs1 != 5'd0) begin
			rdata1 = regs[rs1];
		end
		if (rs2 != 5'd0) begin
			rdata2 = regs[rs2];
		end
	end

	// no write-to-read bypass, the write lands at the edge

endmodule

// ==== design/npc_idu.sv ====
// rv64i decode unit
`timescale 1ns/1ps

module npc_idu (
	input  npc_pkg::inst_u inst,
	output npc_pkg::dec_t  dec
);

	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       f7_zero;
	logic       f7_alt;
	logic       reg_ok;
	logic       word_f3_ok;
	logic       imm_shift_ok;

	logic [npc_pkg::xlen-1:0] imm_i;
	logic [npc_pkg::xlen-1:0] imm_b;
	logic [npc_pkg::xlen-1:0] imm_u;
	logic [npc_pkg::xlen-1:0] imm_j;

	// funct3 picks the op, alt selects sub or sra
	function automatic npc_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  alu_sel = alt ? npc_pkg::alu_sub : npc_pkg::alu_add;
			3'b001:  alu_sel = npc_pkg::alu_sll;
			3'b010:  alu_sel = npc_pkg::alu_slt;
			3'b011:  alu_sel = npc_pkg::alu_sltu;
			3'b100:  alu_sel = npc_pkg::alu_xor;
			3'b101:  alu_sel = alt ? npc_pkg::alu_sra : npc_pkg::alu_srl;
			3'b110:  alu_sel = npc_pkg::alu_or;
			default: alu_sel = npc_pkg::alu_and;
		endcase
	endfunction

	assign funct3 = inst.r_fmt.funct3;
	assign funct7 = inst.r_fmt.funct7;
	assign f7_zero = (funct7 == 7'b0000000);
	assign f7_alt  = (funct7 == 7'b0100000);
	// alt form only exists for add/sub and srl/sra
	assign reg_ok = f7_zero | (f7_alt & ((funct3 == 3'b000) | (funct3 == 3'b101)));
	// word ops exist only for add, sll, srl/sra
	assign word_f3_ok = (funct3 == 3'b000) | (funct3 == 3'b001) | (funct3 == 3'b101);
	// rv64 shifts take a 6-bit shamt, imm[11:6] is the selector
	assign imm_shift_ok = (funct3 == 3'b001) ? (funct7[6:1] == 6'b000000) :
		(funct3 == 3'b101) ? ((funct7[6:1] == 6'b000000) | (funct7[6:1] == 6'b010000)) :
		1'b1;

	// immediates, all sign-extended from inst[31]
	assign imm_i = {{52{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
	assign imm_b = {{51{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi[6], inst.s_fmt.imm_lo[0],
		inst.s_fmt.imm_hi[5:0], inst.s_fmt.imm_lo[4:1], 1'b0};
	assign imm_u = {{32{inst.u_fmt.imm[19]}}, inst.u_fmt.imm, 12'b0};
	assign imm_j = {{43{inst.u_fmt.imm[19]}}, inst.u_fmt.imm[19], inst.u_fmt.imm[7:0],
		inst.u_fmt.imm[8], inst.u_fmt.imm[18:9], 1'b0};

	always_comb begin
		dec        = '0;
		dec.rd     = inst.r_fmt.rd;
		dec.rs1    = inst.r_fmt.rs1;
		dec.rs2    = inst.r_fmt.rs2;
		dec.alu_op = npc_pkg::alu_add;
		dec.br_op  = npc_pkg::br_none;
		case (inst.r_fmt.opcode)
			npc_pkg::op_lui: begin
				// x0 plus imm
				dec.rs1       = 5'd0;
				dec.src_b_imm = 1'b1;
				dec.rd_we     = 1'b1;
				dec.imm       = imm_u;
			end
			npc_pkg::op_auipc: begin
				dec.src_a_pc  = 1'b1;
				dec.src_b_imm = 1'b1;
				dec.rd_we     = 1'b1;
				dec.imm       = imm_u;
			end
			npc_pkg::op_jal: begin
				dec.br_op      = npc_pkg::br_jal;
				dec.rd_we      = 1'b1;
				dec.rd_is_link = 1'b1;
				dec.imm        = imm_j;
			end
			npc_pkg::op_jalr: begin
				// alu forms rs1 + imm for the target
				dec.br_op      = npc_pkg::br_jalr;
				dec.src_b_imm  = 1'b1;
				dec.rd_we      = 1'b1;
				dec.rd_is_link = 1'b1;
				dec.imm        = imm_i;
				dec.illegal    = (inst.i_fmt.funct3 != 3'b000);
			end
			npc_pkg::op_branch: begin
				dec.imm = imm_b;
				case (funct3)
					3'b000:  dec.br_op = npc_pkg::br_beq;
					3'b001:  dec.br_op = npc_pkg::br_bne;
					3'b100:  dec.br_op = npc_pkg::br_blt;
					3'b101:  dec.br_op = npc_pkg::br_bge;
					3'b110:  dec.br_op = npc_pkg::br_bltu;
					3'b111:  dec.br_op = npc_pkg::br_bgeu;
					default: dec.illegal = 1'b1;
				endcase
			end
			npc_pkg::op_imm: begin
				dec.src_b_imm = 1'b1;
				dec.rd_we     = 1'b1;
				dec.imm       = imm_i;
				dec.alu_op    = alu_sel(funct3, (funct3 == 3'b101) & funct7[5]);
				dec.illegal   = !imm_shift_ok;
			end
			npc_pkg::op_imm_32: begin
				// slliw/srliw/sraiw keep a 5-bit shamt
				dec.src_b_imm = 1'b1;
				dec.word_op   = 1'b1;
				dec.rd_we     = 1'b1;
				dec.imm       = imm_i;
				dec.alu_op    = alu_sel(funct3, (funct3 == 3'b101) & funct7[5]);
				dec.illegal   = !(word_f3_ok & ((funct3 == 3'b000) | reg_ok));
			end
			npc_pkg::op_reg: begin
				dec.rd_we   = 1'b1;
				dec.alu_op  = alu_sel(funct3, funct7[5]);
				dec.illegal = !reg_ok;
			end
			npc_pkg::op_reg_32: begin
				dec.word_op = 1'b1;
				dec.rd_we   = 1'b1;
				dec.alu_op  = alu_sel(funct3, funct7[5]);
				dec.illegal = !(word_f3_ok & reg_ok);
			end
			npc_pkg::op_system: begin
				// no csrs, ecall and friends trap as illegal
				dec.ebreak  = (inst == npc_pkg::inst_ebreak);
				dec.illegal = (inst != npc_pkg::inst_ebreak);
			end
			default: dec.illegal = 1'b1;
		endcase
	end

endmodule

// ==== design/npc_ifu.sv ====
// rv64i fetch unit
`timescale 1ns/1ps

module npc_ifu (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [npc_pkg::xlen-1:0]  dnpc,
	input  logic                      take_halt,
	output logic [npc_pkg::xlen-1:0]  pc,
	output logic                      halted
);

	// pc register and sticky halt flag
	always_ff @(posedge clk) begin
		if (rst) begin
			pc     <= npc_pkg::reset_pc;
			halted <= 1'b0;
		end else if (take_halt) begin
			// ebreak or illegal word, freeze here
			halted <= 1'b1;
		end else if (!halted) begin
			pc <= dnpc;
		end
	end

	// pc holds once halted, only reset clears it

endmodule

// ==== design/npc_pkg.sv ====
// rv64i core shared definitions
package npc_pkg;

	// register and instruction widths
	localparam int xlen = 64;
	localparam int ilen = 32;

	// first fetch address after reset
	localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000;

	// major opcodes of the kept subset
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_imm_32 = 7'b0011011;
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_reg_32 = 7'b0111011;
	localparam logic [6:0] op_system = 7'b1110011;

	// the only system encoding that is accepted
	localparam logic [ilen-1:0] inst_ebreak = 32'h0010_0073;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_t;

	// control transfer kinds
	typedef enum logic [3:0] {
		br_none,
		br_beq,
		br_bne,
		br_blt,
		br_bge,
		br_bltu,
		br_bgeu,
		br_jal,
		br_jalr
	} br_op_t;

	// instruction format views, msb first
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// also carries the scrambled b-type offset
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// jal offset bits sit in the same upper field
	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		u_fmt_t u_fmt;
	} inst_u;

	// one decoded instruction, decode to execute
	typedef struct packed {
		logic [4:0]      rd;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		alu_op_t         alu_op;
		br_op_t          br_op;
		logic            src_a_pc;
		logic            src_b_imm;
		logic            word_op;
		logic            rd_we;
		logic            rd_is_link;
		logic            ebreak;
		logic            illegal;
		logic [xlen-1:0] imm;
	} dec_t;

	// retirement report
	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [ilen-1:0] inst;
		logic            wb_en;
		logic [4:0]      wb_rd;
		logic [xlen-1:0] wb_data;
	} retire_t;

endpackage
